//--- verilog/loader_pkg.sv
// Image loader shared types, file kinds, index codes and memory map
`default_nettype none

package loader_pkg;

	// ==============================
	// Widths
	// ==============================
	typedef logic [7:0]  byte_t;
	typedef logic [15:0] word_t;
	typedef logic [24:0] mem_addr_t;
	typedef logic [24:0] stream_off_t;
	typedef logic [31:0] blk_len_t;

	// Kind of the image being downloaded
	typedef enum logic [2:0] {
		KIND_NONE = 3'd0,
		KIND_PRG  = 3'd1,
		KIND_CRT  = 3'd2,
		KIND_TAP  = 3'd3,
		KIND_REU  = 3'd4
	} file_kind_e;

	// Load sequencer states
	typedef enum logic [1:0] {
		SEQ_IDLE   = 2'd0,
		SEQ_STREAM = 2'd1,
		SEQ_INJECT = 2'd2
	} seq_state_e;

	// ==============================
	// Host index codes
	// ==============================
	localparam byte_t IDX_PRG     = 8'h01;
	localparam byte_t IDX_CRT     = 8'h41;
	localparam byte_t IDX_CRT_ALT = 8'h05;
	localparam byte_t IDX_TAP     = 8'hC1;
	localparam byte_t IDX_REU     = 8'h81;

	// Fixed load areas in system memory
	localparam mem_addr_t CRT_BASE = 25'h0100000;
	localparam mem_addr_t TAP_BASE = 25'h0200000;
	localparam mem_addr_t REU_BASE = 25'h1000000;

	// Cartridge layout
	localparam stream_off_t CHIP_AREA_OFF = 25'h40;
	localparam int          CHIP_HDR_LEN  = 16;

	// Page zero scan range for the BASIC pointer injection
	localparam int INJECT_LAST = 'hFF;

endpackage

`default_nettype wire

//--- verilog/image_decode.sv
// Download front end: registers stream bytes, classifies the index, flags start and end
`default_nettype none
`timescale 1ns/1ps

module image_decode (
	input  logic                    clk_sys,
	input  logic                    RESET,
	input  logic                    dl_active_i,
	input  logic                    dl_wr_i,
	input  loader_pkg::byte_t       dl_index_i,
	input  loader_pkg::stream_off_t dl_addr_i,
	input  loader_pkg::byte_t       dl_data_i,
	output logic                    byte_stb_o,
	output loader_pkg::file_kind_e  kind_o,
	output loader_pkg::stream_off_t offset_o,
	output loader_pkg::byte_t       data_o,
	output logic                    dl_start_stb_o,
	output logic                    dl_end_stb_o
);
	import loader_pkg::*;

	logic       active_d;
	file_kind_e kind_dec;

	// Index code to file kind
	always_comb begin
		case (dl_index_i)
			IDX_PRG:              kind_dec = KIND_PRG;
			IDX_CRT, IDX_CRT_ALT: kind_dec = KIND_CRT;
			IDX_TAP:              kind_dec = KIND_TAP;
			IDX_REU:              kind_dec = KIND_REU;
			default:              kind_dec = KIND_NONE;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			active_d       <= 1'b0;
			byte_stb_o     <= 1'b0;
			dl_start_stb_o <= 1'b0;
			dl_end_stb_o   <= 1'b0;
			kind_o         <= KIND_NONE;
		end else begin
			active_d       <= dl_active_i;
			byte_stb_o     <= dl_wr_i;
			dl_start_stb_o <= dl_active_i & ~active_d;
			dl_end_stb_o   <= ~dl_active_i & active_d;
			// Kind stays frozen after the download so the end strobe still carries it
			if (dl_active_i) begin
				kind_o <= kind_dec;
			end
		end
	end

	// Byte and its offset
	always_ff @(posedge clk_sys) begin
		if (dl_wr_i) begin
			offset_o <= dl_addr_i;
			data_o   <= dl_data_i;
		end
	end

endmodule

`default_nettype wire

//--- verilog/crt_header_parser.sv
// Cartridge image parser for file header fields, chip packet headers and payload bytes
`default_nettype none
`timescale 1ns/1ps

module crt_header_parser (
	input  logic                    clk_sys,
	input  logic                    RESET,
	input  logic                    byte_stb_i,
	input  loader_pkg::file_kind_e  kind_i,
	input  loader_pkg::stream_off_t offset_i,
	input  loader_pkg::byte_t       data_i,
	output logic                    payload_stb_o,
	output logic                    chip_start_stb_o,
	output logic                    bank_wr_o,
	output loader_pkg::word_t       cart_id_o,
	output loader_pkg::byte_t       cart_exrom_o,
	output loader_pkg::byte_t       cart_game_o,
	output loader_pkg::byte_t       bank_type_o,
	output loader_pkg::word_t       bank_num_o,
	output loader_pkg::word_t       bank_laddr_o,
	output loader_pkg::word_t       bank_size_o
);
	import loader_pkg::*;

	// File header field offsets
	localparam stream_off_t OFF_ID_HI = 25'h16;
	localparam stream_off_t OFF_ID_LO = 25'h17;
	localparam stream_off_t OFF_EXROM = 25'h18;
	localparam stream_off_t OFF_GAME  = 25'h19;

	localparam logic [3:0] HDR_LAST = 4'(CHIP_HDR_LEN - 1);

	logic       crt_byte;
	logic       in_chips;
	logic       hdr_first;
	logic [3:0] hdr_cnt;
	blk_len_t   blk_len;

	assign crt_byte  = byte_stb_i && (kind_i == KIND_CRT);
	assign in_chips  = offset_i >= CHIP_AREA_OFF;
	// No header in progress and previous payload used up
	assign hdr_first = (blk_len == '0) && (hdr_cnt == '0);

	assign chip_start_stb_o = crt_byte && in_chips && hdr_first;
	assign payload_stb_o    = crt_byte && in_chips && !hdr_first && (hdr_cnt == '0);

	// ==============================
	// Packet tracking
	// ==============================
	always_ff @(posedge clk_sys) begin
		bank_wr_o <= 1'b0;
		if (RESET) begin
			hdr_cnt   <= '0;
			blk_len   <= '0;
			bank_wr_o <= 1'b0;
		end else if (crt_byte) begin
			if (offset_i == '0) begin
				hdr_cnt <= '0;
				blk_len <= '0;
			end else if (chip_start_stb_o) begin
				hdr_cnt <= 4'd1;
			end else if (in_chips && (hdr_cnt != '0)) begin
				// Wraps to zero after the last header byte
				hdr_cnt <= hdr_cnt + 4'd1;
				case (hdr_cnt)
					4'd4:     blk_len[31:24] <= data_i;
					4'd5:     blk_len[23:16] <= data_i;
					4'd6:     blk_len[15:8]  <= data_i;
					4'd7:     blk_len[7:0]   <= data_i;
					4'd8:     blk_len <= blk_len - blk_len_t'(CHIP_HDR_LEN);
					HDR_LAST: bank_wr_o <= 1'b1;
					default:  ;
				endcase
			end else if (payload_stb_o) begin
				blk_len <= blk_len - 1'b1;
			end
		end
	end

	// ==============================
	// Captured fields
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (crt_byte) begin
			case (offset_i)
				OFF_ID_HI: cart_id_o[15:8] <= data_i;
				OFF_ID_LO: cart_id_o[7:0]  <= data_i;
				OFF_EXROM: cart_exrom_o    <= data_i;
				OFF_GAME:  cart_game_o     <= data_i;
				default:   ;
			endcase
			if (in_chips && (hdr_cnt != '0)) begin
				// Only the low byte of the 16-bit chip type is kept
				case (hdr_cnt)
					4'd9:  bank_type_o        <= data_i;
					4'd10: bank_num_o[15:8]   <= data_i;
					4'd11: bank_num_o[7:0]    <= data_i;
					4'd12: bank_laddr_o[15:8] <= data_i;
					4'd13: bank_laddr_o[7:0]  <= data_i;
					4'd14: bank_size_o[15:8]  <= data_i;
					4'd15: bank_size_o[7:0]   <= data_i;
					default: ;
				endcase
			end
		end
	end

	// Bank header writes stay within a cartridge download
	a_bank_wr_in_crt: assert property (@(posedge clk_sys) disable iff (RESET)
		bank_wr_o |-> (kind_i == KIND_CRT));

endmodule

`default_nettype wire

//--- verilog/load_sequencer.sv
// Load sequencer: load address, per-byte write requests and BASIC pointer injection
`default_nettype none
`timescale 1ns/1ps

module load_sequencer #(
	parameter int ALIGN_BITS = 13
) (
	input  logic                    clk_sys,
	input  logic                    RESET,
	input  logic                    byte_stb_i,
	input  loader_pkg::file_kind_e  kind_i,
	input  loader_pkg::stream_off_t offset_i,
	input  loader_pkg::byte_t       data_i,
	input  logic                    dl_start_stb_i,
	input  logic                    dl_end_stb_i,
	input  logic                    payload_stb_i,
	input  logic                    chip_start_stb_i,
	input  logic                    pending_i,
	output logic                    req_stb_o,
	output loader_pkg::mem_addr_t   req_addr_o,
	output loader_pkg::byte_t       req_data_o,
	output logic                    busy_o,
	output logic                    inject_done_o
);
	import loader_pkg::*;

	localparam int AW = $bits(mem_addr_t);

	seq_state_e state_q;
	mem_addr_t  load_addr;
	mem_addr_t  start_base;
	mem_addr_t  addr_now;
	word_t      end_ptr;
	logic       start_ok;
	logic       streaming;
	logic       wr_byte;
	logic       inj_step;
	logic       inj_hit;
	byte_t      inj_data;

	always_comb begin
		case (kind_i)
			KIND_CRT: start_base = CRT_BASE;
			KIND_TAP: start_base = TAP_BASE;
			KIND_REU: start_base = REU_BASE;
			default:  start_base = '0;
		endcase
	end

	assign start_ok  = dl_start_stb_i && (state_q != SEQ_INJECT);
	assign streaming = (state_q == SEQ_STREAM) || start_ok;
	// Base takes effect at once if the first byte arrives with the start strobe
	assign addr_now  = start_ok ? start_base : load_addr;
	assign inj_step  = (state_q == SEQ_INJECT) && !pending_i && !req_stb_o;

	// Bytes that go to memory
	always_comb begin
		wr_byte = 1'b0;
		if (streaming && byte_stb_i) begin
			case (kind_i)
				KIND_PRG:           wr_byte = offset_i > stream_off_t'(1);
				KIND_CRT:           wr_byte = payload_stb_i;
				KIND_TAP, KIND_REU: wr_byte = 1'b1;
				default:            wr_byte = 1'b0;
			endcase
		end
	end

	// BASIC pointers as a LOAD would leave them
	always_comb begin
		inj_hit = 1'b1;
		case (load_addr[7:0])
			8'h2B:                      inj_data = 8'h01;
			8'h2C:                      inj_data = 8'h08;
			8'hAC, 8'hAD:               inj_data = 8'h00;
			8'h2D, 8'h2F, 8'h31, 8'hAE: inj_data = end_ptr[7:0];
			8'h2E, 8'h30, 8'h32, 8'hAF: inj_data = end_ptr[15:8];
			default: begin
				inj_hit  = 1'b0;
				inj_data = 8'h00;
			end
		endcase
	end

	// ==============================
	// Control
	// ==============================
	always_ff @(posedge clk_sys) begin
		req_stb_o     <= 1'b0;
		inject_done_o <= 1'b0;
		if (RESET) begin
			state_q   <= SEQ_IDLE;
			load_addr <= '0;
			end_ptr   <= '0;
		end else begin
			if (start_ok) begin
				state_q   <= SEQ_STREAM;
				load_addr <= start_base;
			end
			// PRG header holds the load address
			if (streaming && byte_stb_i && (kind_i == KIND_PRG)) begin
				if (offset_i == '0) begin
					load_addr <= mem_addr_t'(data_i);
					end_ptr   <= word_t'(data_i);
				end else if (offset_i == stream_off_t'(1)) begin
					load_addr[15:8] <= data_i;
					end_ptr[15:8]   <= data_i;
				end
			end
			// Chip payloads start on an alignment boundary
			if (streaming && chip_start_stb_i && (addr_now[ALIGN_BITS-1:0] != '0)) begin
				load_addr <= {addr_now[AW-1:ALIGN_BITS] + 1'b1, {ALIGN_BITS{1'b0}}};
			end
			if (wr_byte) begin
				req_stb_o <= 1'b1;
				load_addr <= addr_now + 1'b1;
				if (kind_i == KIND_PRG) begin
					end_ptr <= addr_now[15:0] + 16'd1;
				end
			end
			if ((state_q == SEQ_STREAM) && dl_end_stb_i) begin
				if (kind_i == KIND_PRG) begin
					state_q   <= SEQ_INJECT;
					load_addr <= '0;
				end else begin
					state_q <= SEQ_IDLE;
				end
			end
			// One page zero address per step, waits while a write is outstanding
			if (inj_step) begin
				if (load_addr > mem_addr_t'(INJECT_LAST)) begin
					state_q       <= SEQ_IDLE;
					inject_done_o <= 1'b1;
				end else begin
					load_addr <= load_addr + 1'b1;
					req_stb_o <= inj_hit;
				end
			end
		end
	end

	// Request address and data
	always_ff @(posedge clk_sys) begin
		if (wr_byte) begin
			req_addr_o <= addr_now;
			req_data_o <= data_i;
		end else if (inj_step && inj_hit) begin
			req_addr_o <= load_addr;
			req_data_o <= inj_data;
		end
	end

	assign busy_o = byte_stb_i | req_stb_o | pending_i | (state_q == SEQ_INJECT);

	// The write port holds a single entry
	a_no_req_when_pending: assert property (@(posedge clk_sys) disable iff (RESET)
		req_stb_o |-> !pending_i);

endmodule

`default_nettype wire

//--- verilog/mem_write_port.sv
// Single-entry write buffer that issues into the next granted memory slot
`default_nettype none
`timescale 1ns/1ps

module mem_write_port (
	input  logic                  clk_sys,
	input  logic                  RESET,
	input  logic                  req_stb_i,
	input  loader_pkg::mem_addr_t req_addr_i,
	input  loader_pkg::byte_t     req_data_i,
	input  logic                  slot_i,
	output logic                  pending_o,
	output logic                  mem_we_o,
	output loader_pkg::mem_addr_t mem_addr_o,
	output loader_pkg::byte_t     mem_data_o
);

	// ==============================
	// Slot handshake
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			pending_o <= 1'b0;
			mem_we_o  <= 1'b0;
		end else begin
			mem_we_o <= slot_i & pending_o;
			if (slot_i && pending_o) begin
				pending_o <= 1'b0;
			end
			if (req_stb_i) begin
				pending_o <= 1'b1;
			end
		end
	end

	// Address and data hold until the next request
	always_ff @(posedge clk_sys) begin
		if (req_stb_i) begin
			mem_addr_o <= req_addr_i;
			mem_data_o <= req_data_i;
		end
	end

	// A pending write is never overwritten by a new request
	a_no_overwrite: assert property (@(posedge clk_sys) disable iff (RESET)
		req_stb_i |-> !pending_o);

endmodule

`default_nettype wire

//--- verilog/image_loader_top.sv
// Image loader top level: decode, cartridge parse, load sequencing and memory write
`default_nettype none
`timescale 1ns/1ps

module image_loader_top #(
	parameter int ALIGN_BITS = 13
) (
	input  logic                    clk_sys,
	input  logic                    RESET,
	// Host stream
	input  logic                    dl_active_i,
	input  loader_pkg::byte_t       dl_index_i,
	input  logic                    dl_wr_i,
	input  loader_pkg::stream_off_t dl_addr_i,
	input  loader_pkg::byte_t       dl_data_i,
	output logic                    busy_o,
	// Memory slot and write
	input  logic                    slot_i,
	output logic                    mem_we_o,
	output loader_pkg::mem_addr_t   mem_addr_o,
	output loader_pkg::byte_t       mem_data_o,
	output logic                    inject_done_o,
	// Cartridge and bank info
	output loader_pkg::word_t       cart_id_o,
	output loader_pkg::byte_t       cart_exrom_o,
	output loader_pkg::byte_t       cart_game_o,
	output logic                    bank_wr_o,
	output loader_pkg::byte_t       bank_type_o,
	output loader_pkg::word_t       bank_num_o,
	output loader_pkg::word_t       bank_laddr_o,
	output loader_pkg::word_t       bank_size_o
);
	import loader_pkg::*;

	logic        byte_stb;
	file_kind_e  kind;
	stream_off_t offset;
	byte_t       data;
	logic        dl_start_stb;
	logic        dl_end_stb;
	logic        payload_stb;
	logic        chip_start_stb;
	logic        req_stb;
	mem_addr_t   req_addr;
	byte_t       req_data;
	logic        pending;

	// ==============================
	// Decode
	// ==============================
	image_decode u_image_decode (
		.clk_sys        (clk_sys),
		.RESET          (RESET),
		.dl_active_i    (dl_active_i),
		.dl_wr_i        (dl_wr_i),
		.dl_index_i     (dl_index_i),
		.dl_addr_i      (dl_addr_i),
		.dl_data_i      (dl_data_i),
		.byte_stb_o     (byte_stb),
		.kind_o         (kind),
		.offset_o       (offset),
		.data_o         (data),
		.dl_start_stb_o (dl_start_stb),
		.dl_end_stb_o   (dl_end_stb)
	);

	// ==============================
	// Execute
	// ==============================
	crt_header_parser u_crt_header_parser (
		.clk_sys          (clk_sys),
		.RESET            (RESET),
		.byte_stb_i       (byte_stb),
		.kind_i           (kind),
		.offset_i         (offset),
		.data_i           (data),
		.payload_stb_o    (payload_stb),
		.chip_start_stb_o (chip_start_stb),
		.bank_wr_o        (bank_wr_o),
		.cart_id_o        (cart_id_o),
		.cart_exrom_o     (cart_exrom_o),
		.cart_game_o      (cart_game_o),
		.bank_type_o      (bank_type_o),
		.bank_num_o       (bank_num_o),
		.bank_laddr_o     (bank_laddr_o),
		.bank_size_o      (bank_size_o)
	);

	load_sequencer #(
		.ALIGN_BITS (ALIGN_BITS)
	) u_load_sequencer (
		.clk_sys          (clk_sys),
		.RESET            (RESET),
		.byte_stb_i       (byte_stb),
		.kind_i           (kind),
		.offset_i         (offset),
		.data_i           (data),
		.dl_start_stb_i   (dl_start_stb),
		.dl_end_stb_i     (dl_end_stb),
		.payload_stb_i    (payload_stb),
		.chip_start_stb_i (chip_start_stb),
		.pending_i        (pending),
		.req_stb_o        (req_stb),
		.req_addr_o       (req_addr),
		.req_data_o       (req_data),
		.busy_o           (busy_o),
		.inject_done_o    (inject_done_o)
	);

	// ==============================
	// Result
	// ==============================
	mem_write_port u_mem_write_port (
		.clk_sys    (clk_sys),
		.RESET      (RESET),
		.req_stb_i  (req_stb),
		.req_addr_i (req_addr),
		.req_data_i (req_data),
		.slot_i     (slot_i),
		.pending_o  (pending),
		.mem_we_o   (mem_we_o),
		.mem_addr_o (mem_addr_o),
		.mem_data_o (mem_data_o)
	);

endmodule

`default_nettype wire

//--- sim/loader_tb.sv
// Image loader testbench: streams PRG, CRT, TAP and REU images and checks every memory write
`default_nettype none
`timescale 1ns/1ps

module loader_tb;
	import loader_pkg::*;

	localparam int ALIGN_BITS   = 13;
	localparam int PRG_LEN      = 20;
	localparam int BUSY_LIMIT   = 200;
	localparam int DRAIN_LIMIT  = 2000;
	localparam int INJECT_LIMIT = 5000;

	logic        clk_sys;
	logic        RESET;
	logic        dl_active_i;
	byte_t       dl_index_i;
	logic        dl_wr_i;
	stream_off_t dl_addr_i;
	byte_t       dl_data_i;
	logic        slot_i = 1'b0;
	logic        busy_o;
	logic        mem_we_o;
	mem_addr_t   mem_addr_o;
	byte_t       mem_data_o;
	logic        inject_done_o;
	word_t       cart_id_o;
	byte_t       cart_exrom_o;
	byte_t       cart_game_o;
	logic        bank_wr_o;
	byte_t       bank_type_o;
	word_t       bank_num_o;
	word_t       bank_laddr_o;
	word_t       bank_size_o;

	// Expected writes and bank headers, consumed in order by the monitor
	mem_addr_t   exp_addr[$];
	byte_t       exp_data[$];
	byte_t       exp_bank_type[$];
	word_t       exp_bank_num[$];
	word_t       exp_bank_laddr[$];
	word_t       exp_bank_size[$];
	byte_t       img[$];
	int          rd_idx = 0;
	int          bank_count = 0;
	int          inject_count = 0;
	logic        slot_seen = 1'b0;
	logic [15:0] lfsr_q = 16'd21;

	image_loader_top #(
		.ALIGN_BITS (ALIGN_BITS)
	) dut0 (
		.clk_sys       (clk_sys),
		.RESET         (RESET),
		.dl_active_i   (dl_active_i),
		.dl_index_i    (dl_index_i),
		.dl_wr_i       (dl_wr_i),
		.dl_addr_i     (dl_addr_i),
		.dl_data_i     (dl_data_i),
		.busy_o        (busy_o),
		.slot_i        (slot_i),
		.mem_we_o      (mem_we_o),
		.mem_addr_o    (mem_addr_o),
		.mem_data_o    (mem_data_o),
		.inject_done_o (inject_done_o),
		.cart_id_o     (cart_id_o),
		.cart_exrom_o  (cart_exrom_o),
		.cart_game_o   (cart_game_o),
		.bank_wr_o     (bank_wr_o),
		.bank_type_o   (bank_type_o),
		.bank_num_o    (bank_num_o),
		.bank_laddr_o  (bank_laddr_o),
		.bank_size_o   (bank_size_o)
	);

	initial begin
		clk_sys = 1'b0;
		forever #4 clk_sys = ~clk_sys;
	end

	// ==============================
	// Error reporting
	// ==============================
	task automatic abort_run();
		$display("RESULT: FAIL");
		$fatal(1, "stopping at first error");
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		$display("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp);
		abort_run();
	endtask

	task automatic report_problem(input string what);
		$display("ERROR: %s", what);
		abort_run();
	endtask

	// Fibonacci LFSR, taps 16 14 13 11
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	function automatic mem_addr_t align_up(input mem_addr_t a);
		int unit;
		unit = 1 << ALIGN_BITS;
		return mem_addr_t'(((int'(a) + unit - 1) / unit) * unit);
	endfunction

	// Slot grants, one LFSR step per grant bit
	always @(negedge clk_sys) begin : slot_gen
		logic [15:0] nxt;
		nxt = lfsr_step(lfsr_q);
		lfsr_q <= nxt;
		slot_i <= nxt[0];
	end

	always @(posedge clk_sys) begin
		slot_seen <= slot_i;
	end

	// ==============================
	// Output monitor
	// ==============================
	always @(negedge clk_sys) begin
		if (mem_we_o) begin
			assert (slot_seen) else report_problem("memory write without a slot grant before it");
			assert (rd_idx < exp_addr.size()) else report_problem("memory write while none was expected");
			assert (mem_addr_o == exp_addr[rd_idx])
				else report_mismatch("mem_addr_o", 32'(mem_addr_o), 32'(exp_addr[rd_idx]));
			assert (mem_data_o == exp_data[rd_idx])
				else report_mismatch("mem_data_o", 32'(mem_data_o), 32'(exp_data[rd_idx]));
			rd_idx <= rd_idx + 1;
		end
		if (bank_wr_o) begin
			assert (bank_count < exp_bank_type.size()) else report_problem("unexpected bank header write");
			assert (bank_type_o == exp_bank_type[bank_count])
				else report_mismatch("bank_type_o", 32'(bank_type_o), 32'(exp_bank_type[bank_count]));
			assert (bank_num_o == exp_bank_num[bank_count])
				else report_mismatch("bank_num_o", 32'(bank_num_o), 32'(exp_bank_num[bank_count]));
			assert (bank_laddr_o == exp_bank_laddr[bank_count])
				else report_mismatch("bank_laddr_o", 32'(bank_laddr_o), 32'(exp_bank_laddr[bank_count]));
			assert (bank_size_o == exp_bank_size[bank_count])
				else report_mismatch("bank_size_o", 32'(bank_size_o), 32'(exp_bank_size[bank_count]));
			bank_count <= bank_count + 1;
		end
		if (inject_done_o) begin
			assert (rd_idx == exp_addr.size()) else report_problem("injection done before all writes landed");
			inject_count <= inject_count + 1;
		end
	end

	// ==============================
	// Host side
	// ==============================
	task automatic expect_write(input mem_addr_t a, input byte_t d);
		exp_addr.push_back(a);
		exp_data.push_back(d);
	endtask

	task automatic push_word(input word_t w);
		img.push_back(w[15:8]);
		img.push_back(w[7:0]);
	endtask

	// BASIC pointers in ascending address order
	task automatic expect_pointer_writes(input word_t ep);
		expect_write(25'h2B, 8'h01);
		expect_write(25'h2C, 8'h08);
		expect_write(25'h2D, ep[7:0]);
		expect_write(25'h2E, ep[15:8]);
		expect_write(25'h2F, ep[7:0]);
		expect_write(25'h30, ep[15:8]);
		expect_write(25'h31, ep[7:0]);
		expect_write(25'h32, ep[15:8]);
		expect_write(25'hAC, 8'h00);
		expect_write(25'hAD, 8'h00);
		expect_write(25'hAE, ep[7:0]);
		expect_write(25'hAF, ep[15:8]);
	endtask

	// Chip packet with header, payload and the writes it should produce
	task automatic add_chip(input word_t ctype, input word_t bank, input word_t laddr,
			input int plen, input byte_t first, input mem_addr_t base);
		string    sig;
		blk_len_t len;
		int       k;
		sig = "CHIP";
		len = blk_len_t'(CHIP_HDR_LEN + plen);
		for (k = 0; k < 4; k++) begin
			img.push_back(sig[k]);
		end
		push_word(len[31:16]);
		push_word(len[15:0]);
		push_word(ctype);
		push_word(bank);
		push_word(laddr);
		push_word(word_t'(plen));
		exp_bank_type.push_back(ctype[7:0]);
		exp_bank_num.push_back(bank);
		exp_bank_laddr.push_back(laddr);
		exp_bank_size.push_back(word_t'(plen));
		for (k = 0; k < plen; k++) begin
			img.push_back(byte_t'(first + k));
			expect_write(base + mem_addr_t'(k), byte_t'(first + k));
		end
	endtask

	task automatic send_byte(input stream_off_t off, input byte_t val);
		int n;
		dl_addr_i = off;
		dl_data_i = val;
		dl_wr_i   = 1'b1;
		@(negedge clk_sys);
		dl_wr_i = 1'b0;
		repeat (2) @(negedge clk_sys);
		for (n = 0; n < BUSY_LIMIT && busy_o; n++) @(negedge clk_sys);
		if (busy_o) report_problem("timeout: busy_o stayed high after a stream byte");
	endtask

	task automatic send_image(input byte_t index);
		int n;
		dl_index_i  = index;
		dl_active_i = 1'b1;
		repeat (2) @(negedge clk_sys);
		for (n = 0; n < img.size(); n++) begin
			send_byte(stream_off_t'(n), img[n]);
		end
		dl_active_i = 1'b0;
		repeat (2) @(negedge clk_sys);
	endtask

	task automatic drain_writes();
		int n;
		for (n = 0; n < DRAIN_LIMIT && rd_idx != exp_addr.size(); n++) @(negedge clk_sys);
		if (rd_idx != exp_addr.size()) report_problem("timeout: expected memory writes never arrived");
	endtask

	task automatic await_inject_done();
		int n;
		for (n = 0; n < INJECT_LIMIT && !inject_done_o; n++) @(negedge clk_sys);
		if (!inject_done_o) report_problem("timeout: inject_done_o never pulsed after the PRG");
		@(negedge clk_sys);
	endtask

	task automatic check_quiet(input int cycles);
		int n;
		for (n = 0; n < cycles; n++) begin
			@(negedge clk_sys);
			assert (!mem_we_o && !bank_wr_o && !busy_o && !inject_done_o)
				else report_problem("an output went high after reset before any byte was sent");
		end
	endtask

	// ==============================
	// Stimulus
	// ==============================
	initial begin : stimulus
		int        i;
		mem_addr_t chip2_base;
		RESET       = 1'b1;
		dl_active_i = 1'b0;
		dl_index_i  = '0;
		dl_wr_i     = 1'b0;
		dl_addr_i   = '0;
		dl_data_i   = '0;
		repeat (10) @(negedge clk_sys);
		RESET = 1'b0;
		check_quiet(8);

		// PRG loaded at 0x0801, then the pointer injection
		img.push_back(8'h01);
		img.push_back(8'h08);
		for (i = 0; i < PRG_LEN; i++) begin
			img.push_back(byte_t'(8'h40 + 3 * i));
			expect_write(mem_addr_t'(16'h0801 + i), byte_t'(8'h40 + 3 * i));
		end
		expect_pointer_writes(word_t'(16'h0801 + PRG_LEN));
		send_image(IDX_PRG);
		await_inject_done();
		drain_writes();

		// Cartridge with two chip packets
		img.delete();
		repeat (64) img.push_back(8'h00);
		img['h13] = 8'h40;
		img['h16] = 8'h00;
		img['h17] = 8'h20;
		img['h18] = 8'h00;
		img['h19] = 8'h01;
		add_chip(16'h0000, 16'h0000, 16'h8000, 4, 8'h11, CRT_BASE);
		chip2_base = align_up(CRT_BASE + mem_addr_t'(4));
		add_chip(16'h0002, 16'h0001, 16'hA000, 3, 8'h55, chip2_base);
		send_image(IDX_CRT);
		drain_writes();
		assert (cart_id_o == 16'h0020) else report_mismatch("cart_id_o", 32'(cart_id_o), 32'h20);
		assert (cart_exrom_o == 8'h00) else report_mismatch("cart_exrom_o", 32'(cart_exrom_o), 32'h0);
		assert (cart_game_o == 8'h01) else report_mismatch("cart_game_o", 32'(cart_game_o), 32'h1);

		// Tape then expansion image
		img.delete();
		for (i = 0; i < 5; i++) begin
			img.push_back(byte_t'(8'hC0 + i));
			expect_write(TAP_BASE + mem_addr_t'(i), byte_t'(8'hC0 + i));
		end
		send_image(IDX_TAP);
		drain_writes();
		img.delete();
		for (i = 0; i < 3; i++) begin
			img.push_back(byte_t'(8'hE0 + i));
			expect_write(REU_BASE + mem_addr_t'(i), byte_t'(8'hE0 + i));
		end
		send_image(IDX_REU);
		drain_writes();

		// Room for a stray write to show up
		repeat (8) @(negedge clk_sys);
		if ((inject_count == 1) && (bank_count == 2) && (rd_idx == exp_addr.size())) begin
			$display("RESULT: PASS");
			$finish;
		end else begin
			report_problem("wrong number of injection done or bank header pulses");
		end
	end

endmodule

`default_nettype wire

//--- all.f
verilog/loader_pkg.sv
verilog/image_decode.sv
verilog/crt_header_parser.sv
verilog/load_sequencer.sv
verilog/mem_write_port.sv
verilog/image_loader_top.sv
sim/loader_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds and runs the image loader testbench with Verilator

set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f all.f --top-module loader_tb --Mdir obj_dir -o Vloader_tb
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/Vloader_tb > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "RESULT: FAIL" "$LOG"; then
	echo "simulation reported failure"
	exit 1
fi
if [ $run_status -ne 0 ]; then
	echo "simulator exited with status $run_status"
	exit 1
fi
if ! grep -q "RESULT: PASS" "$LOG"; then
	echo "simulation ended without a result"
	exit 1
fi
exit 0
